//--- cu_sum_kernel.f
logic/cu_config_pkg.sv
logic/graph_data_pkg.sv
logic/sum_ctrl_if.sv
logic/sync_fifo.sv
logic/sum_control_fsm.sv
logic/edge_count_timer.sv
logic/edge_sum_accumulator.sv
logic/write_request_unit.sv
logic/cu_sum_kernel.sv
tests/cu_sum_kernel_assert.sv
tests/cu_sum_kernel_tb.sv

//--- logic/cu_config_pkg.sv
// Compute unit configuration: datapath widths, buffer depths and almost-full margin
`default_nettype none

package cu_config_pkg;

	// Datapath widths
	localparam int VERTEX_W = 32;
	localparam int DEGREE_W = 16;
	localparam int DATA_W   = 32;
	localparam int COUNT_W  = 32;
	localparam int POS_W    = 4;

	// Buffer sizing
	localparam int EDGE_FIFO_DEPTH   = 16;
	localparam int RESULT_FIFO_DEPTH = 8;

	// Almost-full once this many free entries or fewer remain
	localparam int ALFULL_MARGIN = 2;

endpackage

`default_nettype wire

//--- logic/cu_sum_kernel.sv
// Sum compute unit top: edge and result buffers around the control and datapath blocks
`default_nettype none
`timescale 1ns/1ps

module cu_sum_kernel #(
	parameter logic [cu_config_pkg::POS_W-1:0] cu_x = 4'd1,
	parameter logic [cu_config_pkg::POS_W-1:0] cu_y = 4'd1
) (
	input  wire logic                                clock,
	input  wire logic                                rstn,
	input  wire logic                                enable,
	input  wire logic                                job_valid,
	input  wire logic [cu_config_pkg::VERTEX_W-1:0] job_id,
	input  wire logic [cu_config_pkg::DEGREE_W-1:0] job_degree,
	input  wire logic                                edge_valid,
	input  wire logic [cu_config_pkg::DATA_W-1:0]   edge_data,
	output logic                                     edge_request,
	input  wire logic                                write_alfull,
	input  wire logic                                write_bus_grant,
	output logic                                     write_bus_request,
	output logic                                     write_valid,
	output logic      [cu_config_pkg::VERTEX_W-1:0] write_id,
	output logic      [cu_config_pkg::DATA_W-1:0]   write_sum,
	output logic      [cu_config_pkg::POS_W-1:0]    write_cu_x,
	output logic      [cu_config_pkg::POS_W-1:0]    write_cu_y,
	input  wire logic                                resp_valid,
	output logic                                     busy,
	output logic      [cu_config_pkg::COUNT_W-1:0] edge_total_count,
	output logic      [cu_config_pkg::COUNT_W-1:0] resp_total_count
);

	import cu_config_pkg::*;
	import graph_data_pkg::*;

	logic                edge_alfull;
	logic                edge_empty;
	logic                edge_pop;
	edge_word_t          edge_word;
	logic                result_push;
	logic                result_pop;
	logic                result_full;
	logic                result_empty;
	result_t             result_in;
	result_t             result_out;
	logic [VERTEX_W-1:0] vertex_id;

	sum_ctrl_if ctrl ();

	//////////////////////////////////////////////////////////////////////
	// Edge input buffer, which keeps capturing while the unit is frozen
	//////////////////////////////////////////////////////////////////////

	assign edge_request = !edge_alfull;

	sync_fifo #(.item_t(edge_word_t), .depth(EDGE_FIFO_DEPTH)) u_edge_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (edge_valid),
		.push_data(edge_data),
		.pop      (edge_pop),
		.pop_data (edge_word),
		.full     (),
		.alfull   (edge_alfull),
		.empty    (edge_empty)
	);

	//////////////////////////////////////////////////////////////////////
	// Control and accumulation
	//////////////////////////////////////////////////////////////////////

	sum_control_fsm u_control (
		.clock      (clock),
		.rstn       (rstn),
		.enable     (enable),
		.job_valid  (job_valid),
		.job_id     (job_id),
		.job_degree (job_degree),
		.result_full(result_full),
		.result_push(result_push),
		.busy       (busy),
		.vertex_id  (vertex_id),
		.ctrl       (ctrl.fsm)
	);

	edge_count_timer u_counter (
		.clock           (clock),
		.rstn            (rstn),
		.enable          (enable),
		.resp_valid      (resp_valid),
		.ctrl            (ctrl.timer),
		.edge_total_count(edge_total_count),
		.resp_total_count(resp_total_count)
	);

	edge_sum_accumulator #(.cu_x(cu_x), .cu_y(cu_y)) u_accumulator (
		.clock     (clock),
		.rstn      (rstn),
		.enable    (enable),
		.edge_empty(edge_empty),
		.edge_pop  (edge_pop),
		.edge_word (edge_word),
		.vertex_id (vertex_id),
		.result    (result_in),
		.ctrl      (ctrl.accum)
	);

	//////////////////////////////////////////////////////////////////////
	// Result buffer and write bus
	//////////////////////////////////////////////////////////////////////

	sync_fifo #(.item_t(result_t), .depth(RESULT_FIFO_DEPTH)) u_result_fifo (
		.clock    (clock),
		.rstn     (rstn),
		.push     (result_push),
		.push_data(result_in),
		.pop      (result_pop),
		.pop_data (result_out),
		.full     (result_full),
		.alfull   (),
		.empty    (result_empty)
	);

	write_request_unit u_write (
		.clock            (clock),
		.rstn             (rstn),
		.enable           (enable),
		.result_empty     (result_empty),
		.write_alfull     (write_alfull),
		.write_bus_grant  (write_bus_grant),
		.result_pop       (result_pop),
		.result_data      (result_out),
		.write_bus_request(write_bus_request),
		.write_valid      (write_valid),
		.write_id         (write_id),
		.write_sum        (write_sum),
		.write_cu_x       (write_cu_x),
		.write_cu_y       (write_cu_y)
	);

endmodule

`default_nettype wire

//--- logic/edge_count_timer.sv
// Per-vertex edge counter plus running totals of consumed edges and write responses
`default_nettype none
`timescale 1ns/1ps

module edge_count_timer (
	input  wire logic                               clock,
	input  wire logic                               rstn,
	input  wire logic                               enable,
	input  wire logic                               resp_valid,
	sum_ctrl_if.timer                               ctrl,
	output logic      [cu_config_pkg::COUNT_W-1:0] edge_total_count,
	output logic      [cu_config_pkg::COUNT_W-1:0] resp_total_count
);

	import cu_config_pkg::*;

	logic [DEGREE_W-1:0] vertex_count;

	// Degree zero matches straight after start
	assign ctrl.last = (vertex_count == ctrl.degree);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_count     <= '0;
			edge_total_count <= '0;
			resp_total_count <= '0;
		end else if (enable) begin
			if (ctrl.start) begin
				vertex_count <= '0;
			end else if (ctrl.take) begin
				vertex_count <= vertex_count + 1'b1;
			end
			if (ctrl.take) begin
				edge_total_count <= edge_total_count + 1'b1;
			end
			if (resp_valid) begin
				resp_total_count <= resp_total_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/edge_sum_accumulator.sv
// Edge summation datapath: pops edge words, accumulates them and forms the result record
`default_nettype none
`timescale 1ns/1ps

module edge_sum_accumulator #(
	parameter logic [cu_config_pkg::POS_W-1:0] cu_x = 4'd1,
	parameter logic [cu_config_pkg::POS_W-1:0] cu_y = 4'd1
) (
	input  wire logic                                clock,
	input  wire logic                                rstn,
	input  wire logic                                enable,
	input  wire logic                                edge_empty,
	output logic                                     edge_pop,
	input  wire graph_data_pkg::edge_word_t          edge_word,
	input  wire logic [cu_config_pkg::VERTEX_W-1:0] vertex_id,
	output graph_data_pkg::result_t                  result,
	sum_ctrl_if.accum                                ctrl
);

	import cu_config_pkg::*;

	logic              active;
	logic [DATA_W-1:0] sum_q;

	// One edge per cycle until the vertex count reaches its degree
	assign edge_pop  = enable && active && !ctrl.last && !edge_empty;
	assign ctrl.take = edge_pop;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active <= 1'b0;
			sum_q  <= '0;
		end else if (enable) begin
			if (ctrl.start) begin
				active <= 1'b1;
				sum_q  <= '0;
			end else if (ctrl.finish) begin
				active <= 1'b0;
				sum_q  <= '0;
			end else if (edge_pop) begin
				sum_q <= sum_q + edge_word;
			end
		end
	end

	always_comb begin
		result.id   = vertex_id;
		result.sum  = sum_q;
		result.cu_x = cu_x;
		result.cu_y = cu_y;
	end

endmodule

`default_nettype wire

//--- logic/graph_data_pkg.sv
// Graph data records exchanged between the sum compute unit and its environment
`default_nettype none

package graph_data_pkg;

	import cu_config_pkg::*;

	// One vertex job as issued by the job source
	typedef struct packed {
		logic [VERTEX_W-1:0] id;
		logic [DEGREE_W-1:0] degree;
	} vertex_job_t;

	// One edge value from the edge stream
	typedef logic [DATA_W-1:0] edge_word_t;

	// Finished vertex, tagged with the grid position of the unit
	typedef struct packed {
		logic [VERTEX_W-1:0] id;
		logic [DATA_W-1:0]   sum;
		logic [POS_W-1:0]    cu_x;
		logic [POS_W-1:0]    cu_y;
	} result_t;

endpackage

`default_nettype wire

//--- logic/sum_control_fsm.sv
// Job sequencing FSM for one vertex: accept, accumulate, hand the result to the buffer
`default_nettype none
`timescale 1ns/1ps

module sum_control_fsm (
	input  wire logic                                clock,
	input  wire logic                                rstn,
	input  wire logic                                enable,
	input  wire logic                                job_valid,
	input  wire logic [cu_config_pkg::VERTEX_W-1:0] job_id,
	input  wire logic [cu_config_pkg::DEGREE_W-1:0] job_degree,
	input  wire logic                                result_full,
	output logic                                     result_push,
	output logic                                     busy,
	output logic      [cu_config_pkg::VERTEX_W-1:0] vertex_id,
	sum_ctrl_if.fsm                                  ctrl
);

	import cu_config_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_accumulate,
		st_finish
	} state_t;

	state_t              state;
	logic                accept;
	logic [DEGREE_W-1:0] degree_q;

	// Jobs arriving while busy are dropped
	assign accept = enable && job_valid && !busy;

	assign ctrl.start  = accept;
	assign ctrl.degree = degree_q;

	// Hand off only when the result buffer has room
	assign result_push = enable && (state == st_finish) && !result_full;
	assign ctrl.finish = result_push;

	//////////////////////////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= st_idle;
			degree_q <= '0;
		end else if (enable) begin
			if (accept) begin
				degree_q <= job_degree;
			end
			case (state)
				st_idle:       if (accept) state <= st_accumulate;
				st_accumulate: if (ctrl.last) state <= st_finish;
				st_finish:     if (result_push) state <= st_idle;
				default:       state <= st_idle;
			endcase
		end
	end

	// Busy drops one cycle after the push, as the write request rises
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= 1'b0;
		end else if (enable) begin
			if (accept) begin
				busy <= 1'b1;
			end else if (state == st_idle) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			vertex_id <= job_id;
		end
	end

endmodule

`default_nettype wire

//--- logic/sum_ctrl_if.sv
// Control link between the sum FSM, the edge counter and the accumulator
`default_nettype none
`timescale 1ns/1ps

interface sum_ctrl_if;

	import cu_config_pkg::*;

	logic                start;
	logic [DEGREE_W-1:0] degree;
	logic                take;
	logic                last;
	logic                finish;

	modport fsm (output start, output degree, output finish, input last);

	modport timer (input start, input degree, input take, output last);

	// Accumulator only sees the edge-level handshake
	modport accum (input start, input finish, input last, output take);

endinterface

`default_nettype wire

//--- logic/sync_fifo.sv
// Synchronous circular buffer of any payload type with full, almost-full and empty flags
`default_nettype none
`timescale 1ns/1ps

module sync_fifo #(
	parameter type item_t = logic [31:0],
	parameter int  depth  = 16
) (
	input  wire logic  clock,
	input  wire logic  rstn,
	input  wire logic  push,
	input  wire item_t push_data,
	input  wire logic  pop,
	output item_t      pop_data,
	output logic       full,
	output logic       alfull,
	output logic       empty
);

	import cu_config_pkg::*;

	localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_w = $clog2(depth + 1);

	item_t              mem [depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [count_w-1:0] count;
	logic               do_push;
	logic               do_pop;

	// Overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full     = (count == count_w'(depth));
	assign alfull   = (count >= count_w'(depth - ALFULL_MARGIN));
	assign empty    = (count == '0);
	// Head entry is visible in the cycle it is popped
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/write_request_unit.sv
// Write bus side: request while results wait, pop on grant, register the write record
`default_nettype none
`timescale 1ns/1ps

module write_request_unit (
	input  wire logic                                clock,
	input  wire logic                                rstn,
	input  wire logic                                enable,
	input  wire logic                                result_empty,
	input  wire logic                                write_alfull,
	input  wire logic                                write_bus_grant,
	output logic                                     result_pop,
	input  wire graph_data_pkg::result_t             result_data,
	output logic                                     write_bus_request,
	output logic                                     write_valid,
	output logic      [cu_config_pkg::VERTEX_W-1:0] write_id,
	output logic      [cu_config_pkg::DATA_W-1:0]   write_sum,
	output logic      [cu_config_pkg::POS_W-1:0]    write_cu_x,
	output logic      [cu_config_pkg::POS_W-1:0]    write_cu_y
);

	logic request_q;

	// Late grants after the buffer drains are not honored
	assign result_pop = enable && write_bus_grant && !write_alfull && !result_empty;

	// Downstream almost-full masks the request at once
	assign write_bus_request = request_q && !write_alfull;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			request_q   <= 1'b0;
			write_valid <= 1'b0;
		end else begin
			write_valid <= result_pop;
			if (enable) begin
				request_q <= !result_empty;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (result_pop) begin
			write_id   <= result_data.id;
			write_sum  <= result_data.sum;
			write_cu_x <= result_data.cu_x;
			write_cu_y <= result_data.cu_y;
		end
	end

endmodule

`default_nettype wire

//--- tests/cu_sum_kernel_assert.sv
// Concurrent checks on reset values, the write bus handshake and the enable freeze
`default_nettype none
`timescale 1ns/1ps

module cu_sum_kernel_assert (
	input wire logic                                clock,
	input wire logic                                rstn,
	input wire logic                                enable,
	input wire logic                                busy,
	input wire logic                                edge_request,
	input wire logic                                write_alfull,
	input wire logic                                write_bus_request,
	input wire logic                                write_valid,
	input wire logic                                result_pop,
	input wire logic [cu_config_pkg::VERTEX_W-1:0] write_id,
	input wire logic [cu_config_pkg::DATA_W-1:0]   write_sum,
	input wire logic [cu_config_pkg::COUNT_W-1:0]  edge_total_count,
	input wire logic [cu_config_pkg::COUNT_W-1:0]  resp_total_count
);

	int failures = 0;

	reset_outputs: assert property (@(posedge clock) !rstn |-> !busy && !write_bus_request &&
			!write_valid && edge_request && edge_total_count == 0 && resp_total_count == 0)
		else begin
			$error("outputs active during reset");
			failures++;
		end

	// Honored grant to write_valid, exactly one cycle
	grant_to_write: assert property (@(posedge clock) disable iff (!rstn)
			result_pop |=> write_valid)
		else begin
			$error("honored grant without write_valid");
			failures++;
		end

	write_from_grant: assert property (@(posedge clock) disable iff (!rstn)
			write_valid |-> $past(result_pop))
		else begin
			$error("write_valid without an honored grant");
			failures++;
		end

	no_request_alfull: assert property (@(posedge clock) disable iff (!rstn)
			write_alfull |-> !write_bus_request)
		else begin
			$error("request while write_alfull is high");
			failures++;
		end

	no_write_alfull: assert property (@(posedge clock) disable iff (!rstn)
			write_alfull |=> !write_valid)
		else begin
			$error("write issued while write_alfull is high");
			failures++;
		end

	busy_to_request: assert property (@(posedge clock) disable iff (!rstn)
			$fell(busy) && !write_alfull |-> write_bus_request)
		else begin
			$error("busy fell without a write request");
			failures++;
		end

	frozen_state: assert property (@(posedge clock) disable iff (!rstn)
			!enable |=> $stable(busy) && $stable(write_id) && $stable(write_sum) &&
			$stable(edge_total_count) && $stable(resp_total_count))
		else begin
			$error("state changed while enable is low");
			failures++;
		end

endmodule

bind cu_sum_kernel cu_sum_kernel_assert u_assert (
	.clock            (clock),
	.rstn             (rstn),
	.enable           (enable),
	.busy             (busy),
	.edge_request     (edge_request),
	.write_alfull     (write_alfull),
	.write_bus_request(write_bus_request),
	.write_valid      (write_valid),
	.result_pop       (result_pop),
	.write_id         (write_id),
	.write_sum        (write_sum),
	.edge_total_count (edge_total_count),
	.resp_total_count (resp_total_count)
);

`default_nettype wire

//--- tests/cu_sum_kernel_tb.sv
// Testbench for the sum compute unit: random jobs, edge bursts, write bus model, freeze test
`default_nettype none
`timescale 1ns/1ps

module cu_sum_kernel_tb;

	import cu_config_pkg::*;
	import graph_data_pkg::*;

	localparam int num_jobs       = 40;
	localparam int max_degree     = 12;
	localparam int clock_period   = 4;
	localparam int timeout_cycles = (num_jobs + 1) * (max_degree + 24) + 400;

	logic                clock;
	logic                rstn;
	logic                enable;
	logic                job_valid;
	logic [VERTEX_W-1:0] job_id;
	logic [DEGREE_W-1:0] job_degree;
	logic                edge_valid;
	logic [DATA_W-1:0]   edge_data;
	logic                edge_request;
	logic                write_alfull;
	logic                write_bus_grant;
	logic                write_bus_request;
	logic                write_valid;
	logic [VERTEX_W-1:0] write_id;
	logic [DATA_W-1:0]   write_sum;
	logic [POS_W-1:0]    write_cu_x;
	logic [POS_W-1:0]    write_cu_y;
	logic                resp_valid;
	logic                busy;
	logic [COUNT_W-1:0]  edge_total_count;
	logic [COUNT_W-1:0]  resp_total_count;

	logic [31:0]         lcg_state = 32'hdcc4;
	edge_word_t          edge_q [$];
	result_t             expected_q [$];
	result_t             expected;
	int                  resp_due_q [$];
	int                  cycle = 0;
	int                  errors = 0;
	int                  edges_sent = 0;
	int                  resps_sent = 0;
	logic                request_seen = 1'b0;
	logic [VERTEX_W-1:0] ids [num_jobs + 1];
	int                  degrees [num_jobs + 1];
	logic [COUNT_W-1:0]  frozen_edges;
	logic [COUNT_W-1:0]  frozen_resps;
	logic                frozen_busy;

	cu_sum_kernel #(.cu_x(4'd3), .cu_y(4'd5)) u_dut (.*);

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	initial begin
		#(timeout_cycles * clock_period);
		$display("Timeout: the run did not complete within %0d cycles", timeout_cycles);
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Queue the edge values of one job and its expected result
	task automatic queue_job_data(input logic [VERTEX_W-1:0] id, input int degree);
		logic [DATA_W-1:0] sum;
		edge_word_t        value;
		sum = '0;
		for (int e = 0; e < degree; e++) begin
			value = next_random();
			edge_q.push_back(value);
			sum = sum + value;
		end
		expected_q.push_back('{id: id, sum: sum, cu_x: 4'd3, cu_y: 4'd5});
	endtask

	task automatic issue_job(input logic [VERTEX_W-1:0] id, input int degree);
		while (busy) @(negedge clock);
		job_valid  = 1'b1;
		job_id     = id;
		job_degree = DEGREE_W'(degree);
		@(negedge clock);
		job_valid = 1'b0;
	endtask

	task automatic drain_unit();
		do @(negedge clock);
		while (busy || write_bus_request || expected_q.size() > 0 || resp_due_q.size() > 0);
		repeat (4) @(negedge clock);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Edge source, bus model and result checker
	//////////////////////////////////////////////////////////////////////

	// Bursts until the unit withdraws edge_request
	always @(negedge clock) begin
		edge_valid = 1'b0;
		if (rstn && edge_request && edge_q.size() > 0) begin
			edge_valid = 1'b1;
			edge_data  = edge_q.pop_front();
			edges_sent++;
		end
	end

	always @(posedge clock) request_seen <= write_bus_request;

	// Grant one cycle after the request, response three cycles after each write
	always @(negedge clock) begin
		cycle++;
		write_bus_grant = request_seen;
		resp_valid      = 1'b0;
		if (resp_due_q.size() > 0 && resp_due_q[0] == cycle) begin
			resp_valid = 1'b1;
			void'(resp_due_q.pop_front());
			resps_sent++;
		end
		if (rstn && write_valid) resp_due_q.push_back(cycle + 3);
	end

	always @(negedge clock) begin
		if (rstn && write_valid) begin
			if (expected_q.size() == 0) begin
				errors++;
				$display("Unexpected write of vertex %h with no result outstanding", write_id);
			end else begin
				expected = expected_q.pop_front();
				if (write_id !== expected.id || write_sum !== expected.sum ||
						write_cu_x !== expected.cu_x || write_cu_y !== expected.cu_y) begin
					errors++;
					$display("** Error at %0t: write %h/%h/%0d/%0d, expected %h/%h/%0d/%0d",
						$time, write_id, write_sum, write_cu_x, write_cu_y,
						expected.id, expected.sum, expected.cu_x, expected.cu_y);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		rstn         = 1'b0;
		enable       = 1'b1;
		job_valid    = 1'b0;
		job_id       = '0;
		job_degree   = '0;
		edge_valid   = 1'b0;
		edge_data    = '0;
		write_alfull = 1'b0;
		resp_valid   = 1'b0;
		write_bus_grant = 1'b0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;

		// Every tenth job starting at job 2 has no edges
		for (int j = 0; j <= num_jobs; j++) begin
			ids[j]     = next_random();
			degrees[j] = (j % 10 == 2) ? 0 : int'((next_random() >> 8) % (max_degree + 1));
			if (j == num_jobs) degrees[j] = 8;
		end
		for (int j = 0; j < num_jobs; j++) queue_job_data(ids[j], degrees[j]);

		for (int j = 0; j < num_jobs; j++) begin
			if (j == 15) write_alfull = 1'b1;
			if (j == 22) write_alfull = 1'b0;
			// Last results stay buffered until the freeze below
			if (j == num_jobs - 1) write_alfull = 1'b1;
			issue_job(ids[j], degrees[j]);
		end
		while (resp_due_q.size() > 0) @(negedge clock);

		// Freeze partway through one vertex while buffered results see grants
		queue_job_data(ids[num_jobs], degrees[num_jobs]);
		issue_job(ids[num_jobs], degrees[num_jobs]);
		frozen_edges = edge_total_count;
		while (edge_total_count < frozen_edges + 3) @(negedge clock);
		enable       = 1'b0;
		write_alfull = 1'b0;
		frozen_busy  = busy;
		frozen_edges = edge_total_count;
		frozen_resps = resp_total_count;
		repeat (10) @(negedge clock);
		if (busy !== frozen_busy || edge_total_count !== frozen_edges ||
				resp_total_count !== frozen_resps) begin
			errors++;
			$display("** Error at %0t: state moved while enable was low", $time);
		end
		enable = 1'b1;
		drain_unit();

		if (edge_total_count !== COUNT_W'(edges_sent)) begin
			errors++;
			$display("** Error at %0t: edge_total_count %0d, expected %0d",
				$time, edge_total_count, edges_sent);
		end
		if (resp_total_count !== COUNT_W'(resps_sent)) begin
			errors++;
			$display("** Error at %0t: resp_total_count %0d, expected %0d",
				$time, resp_total_count, resps_sent);
		end
		$display("Summary: %0d value errors, %0d assertion failures",
			errors, u_dut.u_assert.failures);
		if (errors == 0 && u_dut.u_assert.failures == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
